//--- tb.f
+incdir+hdl
hdl/dfe_cal_pkg.sv
hdl/dfe_cal_sequencer.sv
hdl/dfe_save_bank.sv
hdl/dfe_word_builder.sv
hdl/dfe_ctrl_master.sv
hdl/dfe_cal_top.sv
dv/dfe_cal_checker.sv
dv/dfe_cal_tb.sv

//--- Bender.yml
package:
  name: dfe_cal

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dfe_cal_pkg.sv
      - hdl/dfe_cal_sequencer.sv
      - hdl/dfe_save_bank.sv
      - hdl/dfe_word_builder.sv
      - hdl/dfe_ctrl_master.sv
      - hdl/dfe_cal_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/dfe_cal_checker.sv
      - dv/dfe_cal_tb.sv

//--- dv/dfe_cal_tb.sv
`include "dfe_cal_params.svh"

module dfe_cal_tb;

    localparam int ROWS        = 4;
    localparam int ROW_TIMEOUT = 200;
    localparam int MAX_DELAY   = 4;

    logic                     clk;
    logic                     reg_count_reset;
    logic                     start;
    logic [`DFE_OFFSET_W-1:0] oc_offset;
    logic [`DFE_WORD_W-1:0]   ctrl_rdata;
    logic                     ctrl_done;
    logic                     busy;
    logic                     done;
    logic                     ctrl_lock;
    logic                     ctrl_req;
    logic [2:0]               ctrl_opcode;
    logic [`DFE_ADDR_W-1:0]   ctrl_addr;
    logic [`DFE_WORD_W-1:0]   ctrl_wdata;

    // PHY user register space
    logic [`DFE_WORD_W-1:0]   phy_mem [0:(1 << `DFE_ADDR_W)-1];

    // -------------------------------------------------------------------
    // stimulus table, one column per array, one row per run
    // -------------------------------------------------------------------
    logic [`DFE_WORD_W-1:0]   tbl_r8 [ROWS]      = '{16'h1234, 16'h0000, 16'hffff, 16'ha5a5};
    logic [`DFE_WORD_W-1:0]   tbl_r11 [ROWS]     = '{16'hc0a5, 16'h7fff, 16'h8000, 16'hffff};
    logic [`DFE_WORD_W-1:0]   tbl_r12 [ROWS]     = '{16'h5f3c, 16'hfe00, 16'h01ff, 16'haaaa};
    logic [`DFE_WORD_W-1:0]   tbl_r13 [ROWS]     = '{16'hbeef, 16'h0001, 16'h8001, 16'h5a5a};
    logic [`DFE_OFFSET_W-1:0] tbl_offset [ROWS]  = '{24'ha1b2c3, 24'h00ff5a, 24'h7e813f,
                                                     24'hffffff};
    // second start pulse in the middle of the run
    logic                     tbl_busy_start [ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1};
    // register 12 and 15 contents expected after done
    logic [`DFE_WORD_W-1:0]   tbl_exp_r12 [ROWS] = '{16'h5fc3, 16'hfe5a, 16'h013f, 16'haaff};
    logic [`DFE_WORD_W-1:0]   tbl_exp_r15 [ROWS] = '{16'ha1b2, 16'h00ff, 16'h7e81, 16'hffff};

    logic [`DFE_WORD_W-1:0]   row_r8;
    logic [`DFE_WORD_W-1:0]   row_r11;
    logic [`DFE_WORD_W-1:0]   row_r12;
    logic [`DFE_WORD_W-1:0]   row_r13;
    logic [`DFE_OFFSET_W-1:0] row_offset;
    logic                     row_ok;
    int                       tb_errors;
    int                       row_cycles;
    int                       checker_errors;
    int                       runs_done;

    dfe_cal_top dut (
        .clk             (clk),
        .reg_count_reset (reg_count_reset),
        .start           (start),
        .oc_offset       (oc_offset),
        .ctrl_rdata      (ctrl_rdata),
        .ctrl_done       (ctrl_done),
        .busy            (busy),
        .done            (done),
        .ctrl_lock       (ctrl_lock),
        .ctrl_req        (ctrl_req),
        .ctrl_opcode     (ctrl_opcode),
        .ctrl_addr       (ctrl_addr),
        .ctrl_wdata      (ctrl_wdata)
    );

    dfe_cal_checker u_checker (
        .clk             (clk),
        .reg_count_reset (reg_count_reset),
        .start           (start),
        .busy            (busy),
        .done            (done),
        .ctrl_lock       (ctrl_lock),
        .ctrl_req        (ctrl_req),
        .ctrl_opcode     (ctrl_opcode),
        .ctrl_addr       (ctrl_addr),
        .ctrl_wdata      (ctrl_wdata),
        .row_r8          (row_r8),
        .row_r11         (row_r11),
        .row_r12         (row_r12),
        .row_r13         (row_r13),
        .row_offset      (row_offset),
        .error_count     (checker_errors),
        .run_count       (runs_done)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic fill_phy_mem();
        for (int a = 0; a < (1 << `DFE_ADDR_W); a++) begin
            phy_mem[a] = {a[3:0], a[11:0]} ^ 16'h6b2d;
        end
    endtask

    task automatic check_register(input logic [`DFE_ADDR_W-1:0] a,
                                  input logic [`DFE_WORD_W-1:0] want,
                                  input string name);
        if (phy_mem[a] !== want) begin
            $display("mismatch at time %0t: %s holds %04h, expected %04h",
                     $time, name, phy_mem[a], want);
            tb_errors++;
        end
    endtask

    // -------------------------------------------------------------------
    // PHY model answer to one request, random ctrl_done delay
    // -------------------------------------------------------------------
    task automatic serve_request(input int row, input int txn);
        int delay;
        begin
            delay = $urandom % (MAX_DELAY + 1);
            #1;
            // extra start while busy, the DUT has to drop it
            if (tbl_busy_start[row] && (txn == 5)) begin
                start     = 1'b1;
                oc_offset = ~tbl_offset[row];
                @(posedge clk);
                row_cycles++;
                #1;
                start = 1'b0;
            end
            repeat (delay) begin
                @(posedge clk);
                row_cycles++;
                #1;
            end
            if (ctrl_opcode == `DFE_OP_RD) begin
                ctrl_rdata = phy_mem[ctrl_addr];
            end else if (ctrl_opcode == `DFE_OP_WR) begin
                phy_mem[ctrl_addr] = ctrl_wdata;
            end else begin
                $display("PHY model received unknown opcode %0h", ctrl_opcode);
                tb_errors++;
            end
            ctrl_done = 1'b1;
            @(posedge clk);
            row_cycles++;
            #1;
            ctrl_done = 1'b0;
        end
    endtask

    task automatic run_row(input int row, output logic ok);
        int   txn;
        logic finished;
        begin
            ok         = 1'b1;
            finished   = 1'b0;
            txn        = 0;
            row_cycles = 0;
            @(posedge clk);
            #1;
            phy_mem[`DFE_ADDR_8]  = tbl_r8[row];
            phy_mem[`DFE_ADDR_11] = tbl_r11[row];
            phy_mem[`DFE_ADDR_12] = tbl_r12[row];
            phy_mem[`DFE_ADDR_13] = tbl_r13[row];
            row_r8     = tbl_r8[row];
            row_r11    = tbl_r11[row];
            row_r12    = tbl_r12[row];
            row_r13    = tbl_r13[row];
            row_offset = tbl_offset[row];
            oc_offset  = tbl_offset[row];
            start      = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
            // serve requests until done, bounded by the row budget
            while (!finished && (row_cycles < ROW_TIMEOUT)) begin
                @(posedge clk);
                row_cycles++;
                if (done) begin
                    finished = 1'b1;
                end else if (ctrl_req) begin
                    serve_request(row, txn);
                    txn++;
                end
            end
            if (!finished) begin
                $display("timeout: row %0d saw no done within %0d cycles", row, ROW_TIMEOUT);
                tb_errors++;
                ok = 1'b0;
            end else begin
                check_register(`DFE_ADDR_8, tbl_r8[row], "register 8");
                check_register(`DFE_ADDR_11, tbl_r11[row], "register 11");
                check_register(`DFE_ADDR_12, tbl_exp_r12[row], "register 12");
                check_register(`DFE_ADDR_13, tbl_r13[row], "register 13");
                check_register(`DFE_ADDR_15, tbl_exp_r15[row], "register 15");
            end
        end
    endtask

    initial begin
        void'($urandom(32'h107e));
        tb_errors       = 0;
        row_ok          = 1'b1;
        reg_count_reset = 1'b1;
        start           = 1'b0;
        oc_offset       = '0;
        ctrl_rdata      = '0;
        ctrl_done       = 1'b0;
        row_r8          = '0;
        row_r11         = '0;
        row_r12         = '0;
        row_r13         = '0;
        row_offset      = '0;
        fill_phy_mem();
        repeat (10) @(posedge clk);
        #1;
        reg_count_reset = 1'b0;
        // a few quiet cycles before the first start
        repeat (3) @(posedge clk);
        for (int row = 0; row < ROWS; row++) begin
            run_row(row, row_ok);
            if (!row_ok)
                break;
        end
        repeat (4) @(posedge clk);
        if (row_ok && (runs_done != ROWS)) begin
            $display("only %0d of %0d runs ended with a done pulse", runs_done, ROWS);
            tb_errors++;
        end
        $display("summary: %0d checker errors, %0d testbench errors", checker_errors, tb_errors);
        if ((checker_errors == 0) && (tb_errors == 0))
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- dv/dfe_cal_checker.sv
`include "dfe_cal_params.svh"

module dfe_cal_checker (
    input  logic                     clk,
    input  logic                     reg_count_reset,
    input  logic                     start,
    input  logic                     busy,
    input  logic                     done,
    input  logic                     ctrl_lock,
    input  logic                     ctrl_req,
    input  logic [2:0]               ctrl_opcode,
    input  logic [`DFE_ADDR_W-1:0]   ctrl_addr,
    input  logic [`DFE_WORD_W-1:0]   ctrl_wdata,
    input  logic [`DFE_WORD_W-1:0]   row_r8,
    input  logic [`DFE_WORD_W-1:0]   row_r11,
    input  logic [`DFE_WORD_W-1:0]   row_r12,
    input  logic [`DFE_WORD_W-1:0]   row_r13,
    input  logic [`DFE_OFFSET_W-1:0] row_offset,
    output int                       error_count,
    output int                       run_count
);

    localparam int RUN_TXNS = 12;

    // row values latched on the accepted start
    logic [`DFE_WORD_W-1:0]   r8;
    logic [`DFE_WORD_W-1:0]   r11;
    logic [`DFE_WORD_W-1:0]   r12;
    logic [`DFE_WORD_W-1:0]   r13;
    logic [`DFE_OFFSET_W-1:0] offset;

    logic [2:0]               held_opcode;
    logic [`DFE_ADDR_W-1:0]   held_addr;
    logic [`DFE_WORD_W-1:0]   held_wdata;
    logic                     run_open;
    logic                     started_once;
    logic                     req_q;
    logic                     lock_q;
    int                       txn_idx;
    int                       errs = 0;
    int                       runs = 0;

    assign error_count = errs;
    assign run_count   = runs;

    task automatic report_mismatch(input string msg);
        $display("mismatch at time %0t: %s", $time, msg);
        errs++;
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        errs++;
    endtask

    // -------------------------------------------------------------------
    // expected {opcode, addr, wdata} of each request in a run
    // -------------------------------------------------------------------
    function automatic logic [30:0] expected_txn(input int idx);
        logic [2:0]             op;
        logic [`DFE_ADDR_W-1:0] a;
        logic [`DFE_WORD_W-1:0] w;
        begin
            op = (idx < 4) ? `DFE_OP_RD : `DFE_OP_WR;
            case (idx)
                0, 8:    a = `DFE_ADDR_8;
                1, 4, 9: a = `DFE_ADDR_11;
                3, 11:   a = `DFE_ADDR_13;
                7:       a = `DFE_ADDR_15;
                default: a = `DFE_ADDR_12;
            endcase
            case (idx)
                4:       w = r11 & 16'h7fff;
                5:       w = {r12[15:9], 1'b1, 8'h00};
                6:       w = {r12[15:9], 1'b1, offset[7:0]};
                7:       w = offset[23:8];
                8:       w = r8;
                9:       w = r11;
                10:      w = {r12[15:8], offset[7:0]};
                11:      w = r13;
                default: w = '0;
            endcase
            return {op, a, w};
        end
    endfunction

    task automatic check_request(input int idx);
        logic [30:0] want;
        begin
            want = expected_txn(idx);
            if (ctrl_opcode !== want[30:28])
                report_mismatch($sformatf("request %0d opcode %0h, expected %0h",
                                          idx, ctrl_opcode, want[30:28]));
            if (ctrl_addr !== want[27:16])
                report_mismatch($sformatf("request %0d address %03h, expected %03h",
                                          idx, ctrl_addr, want[27:16]));
            // read data word carries nothing
            if ((idx >= 4) && (ctrl_wdata !== want[15:0]))
                report_mismatch($sformatf("request %0d write data %04h, expected %04h",
                                          idx, ctrl_wdata, want[15:0]));
        end
    endtask

    // -------------------------------------------------------------------
    // bus and status monitor
    // -------------------------------------------------------------------
    always @(posedge clk) begin
        if (reg_count_reset) begin
            run_open     = 1'b0;
            started_once = 1'b0;
            req_q        = 1'b0;
            lock_q       = 1'b0;
            txn_idx      = 0;
        end else begin
            if (!started_once && (ctrl_req || ctrl_lock || busy || done))
                report_mismatch("bus or status output active before the first start");
            if (run_open && !done && !ctrl_lock)
                report_mismatch("ctrl_lock low in the middle of a run");
            // start only counts while idle
            if (start && !busy) begin
                if (run_open)
                    report_failure("start accepted while a run was still open");
                r8           = row_r8;
                r11          = row_r11;
                r12          = row_r12;
                r13          = row_r13;
                offset       = row_offset;
                txn_idx      = 0;
                run_open     = 1'b1;
                started_once = 1'b1;
            end
            if (ctrl_req && !req_q) begin
                if (!run_open)
                    report_failure("bus request issued outside a run");
                else if (txn_idx >= RUN_TXNS)
                    report_mismatch("more than twelve requests in one run");
                else
                    check_request(txn_idx);
                held_opcode = ctrl_opcode;
                held_addr   = ctrl_addr;
                held_wdata  = ctrl_wdata;
                txn_idx++;
            end else if (ctrl_req && ({ctrl_opcode, ctrl_addr, ctrl_wdata} !==
                                      {held_opcode, held_addr, held_wdata})) begin
                report_mismatch($sformatf("request %0d changed before ctrl_done",
                                          txn_idx - 1));
            end
            if (done) begin
                if (!run_open) begin
                    report_failure("done pulse outside a run");
                end else begin
                    if (txn_idx != RUN_TXNS)
                        report_mismatch($sformatf("run ended after %0d requests, expected %0d",
                                                  txn_idx, RUN_TXNS));
                    if (ctrl_lock || busy)
                        report_mismatch("ctrl_lock or busy still high with done");
                    if (!lock_q)
                        report_mismatch("ctrl_lock low in the cycle before done");
                    run_open = 1'b0;
                    runs++;
                end
            end
            req_q  = ctrl_req;
            lock_q = ctrl_lock;
        end
    end

endmodule

//--- hdl/dfe_cal_top.sv
`include "dfe_cal_params.svh"

module dfe_cal_top (
    input  logic                     clk,
    input  logic                     reg_count_reset,
    input  logic                     start,
    input  logic [`DFE_OFFSET_W-1:0] oc_offset,
    input  logic [`DFE_WORD_W-1:0]   ctrl_rdata,
    input  logic                     ctrl_done,
    output logic                     busy,
    output logic                     done,
    output logic                     ctrl_lock,
    output logic                     ctrl_req,
    output logic [2:0]               ctrl_opcode,
    output logic [`DFE_ADDR_W-1:0]   ctrl_addr,
    output logic [`DFE_WORD_W-1:0]   ctrl_wdata
);

    logic [`DFE_PH_W-1:0]   phase;
    logic [`DFE_CNT_W-1:0]  count;
    logic                   issue;
    logic                   step_done;
    logic [2:0]             opcode;
    logic [`DFE_ADDR_W-1:0] addr;
    logic [`DFE_WORD_W-1:0] wdata;
    dfe_cal_pkg::dfe_reg_u  saved_8;
    dfe_cal_pkg::dfe_reg_u  saved_11;
    dfe_cal_pkg::dfe_reg_u  saved_12;
    dfe_cal_pkg::dfe_reg_u  saved_13;

    dfe_cal_sequencer u_sequencer (
        .clk             (clk),
        .reg_count_reset (reg_count_reset),
        .start           (start),
        .step_done       (step_done),
        .phase           (phase),
        .count           (count),
        .issue           (issue),
        .ctrl_lock       (ctrl_lock),
        .busy            (busy),
        .done            (done)
    );

    dfe_save_bank u_save_bank (
        .clk        (clk),
        .phase      (phase),
        .count      (count),
        .ctrl_rdata (ctrl_rdata),
        .ctrl_done  (ctrl_done),
        .saved_8    (saved_8),
        .saved_11   (saved_11),
        .saved_12   (saved_12),
        .saved_13   (saved_13)
    );

    dfe_word_builder u_word_builder (
        .clk       (clk),
        .start     (start),
        .oc_offset (oc_offset),
        .phase     (phase),
        .count     (count),
        .saved_8   (saved_8),
        .saved_11  (saved_11),
        .saved_12  (saved_12),
        .saved_13  (saved_13),
        .opcode    (opcode),
        .addr      (addr),
        .wdata     (wdata)
    );

    dfe_ctrl_master u_ctrl_master (
        .clk             (clk),
        .reg_count_reset (reg_count_reset),
        .issue           (issue),
        .opcode          (opcode),
        .addr            (addr),
        .wdata           (wdata),
        .ctrl_done       (ctrl_done),
        .ctrl_req        (ctrl_req),
        .ctrl_opcode     (ctrl_opcode),
        .ctrl_addr       (ctrl_addr),
        .ctrl_wdata      (ctrl_wdata),
        .step_done       (step_done)
    );

endmodule

//--- hdl/dfe_ctrl_master.sv
`include "dfe_cal_params.svh"

module dfe_ctrl_master (
    input  logic                   clk,
    input  logic                   reg_count_reset,
    input  logic                   issue,
    input  logic [2:0]             opcode,
    input  logic [`DFE_ADDR_W-1:0] addr,
    input  logic [`DFE_WORD_W-1:0] wdata,
    input  logic                   ctrl_done,
    output logic                   ctrl_req,
    output logic [2:0]             ctrl_opcode,
    output logic [`DFE_ADDR_W-1:0] ctrl_addr,
    output logic [`DFE_WORD_W-1:0] ctrl_wdata,
    output logic                   step_done
);

    // -------------------------------------------------------------------
    // request flag and completion pulse
    // -------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reg_count_reset) begin
            ctrl_req  <= 1'b0;
            step_done <= 1'b0;
        end else begin
            step_done <= ctrl_req && ctrl_done;
            if (issue) begin
                ctrl_req <= 1'b1;
            end else if (ctrl_done) begin
                ctrl_req <= 1'b0;
            end
        end
    end

    // request payload, loaded once per transaction
    always_ff @(posedge clk) begin
        if (issue) begin
            ctrl_opcode <= opcode;
            ctrl_addr   <= addr;
            ctrl_wdata  <= wdata;
        end
    end

    // payload holds for as long as the PHY keeps the request waiting
    assert property (@(posedge clk) disable iff (reg_count_reset)
        (ctrl_req && !ctrl_done) |=>
            (ctrl_req && $stable({ctrl_opcode, ctrl_addr, ctrl_wdata})))
        else $error("bus request changed before ctrl_done");

    // sequencer never issues on top of an outstanding request
    assert property (@(posedge clk) disable iff (reg_count_reset)
        issue |-> !ctrl_req)
        else $error("issue while a request is outstanding");

endmodule

//--- hdl/dfe_word_builder.sv
`include "dfe_cal_params.svh"

module dfe_word_builder (
    input  logic                     clk,
    input  logic                     start,
    input  logic [`DFE_OFFSET_W-1:0] oc_offset,
    input  logic [`DFE_PH_W-1:0]     phase,
    input  logic [`DFE_CNT_W-1:0]    count,
    input  dfe_cal_pkg::dfe_reg_u    saved_8,
    input  dfe_cal_pkg::dfe_reg_u    saved_11,
    input  dfe_cal_pkg::dfe_reg_u    saved_12,
    input  dfe_cal_pkg::dfe_reg_u    saved_13,
    output logic [2:0]               opcode,
    output logic [`DFE_ADDR_W-1:0]   addr,
    output logic [`DFE_WORD_W-1:0]   wdata
);

    logic [`DFE_OFFSET_W-1:0]       offset_q;
    logic [`DFE_OFFSET_FIELD_W-1:0] ofs_od;
    logic [`DFE_OFFSET_FIELD_W-1:0] ofs_ev;
    dfe_cal_pkg::dfe_reg_u          word;

    // offset result is taken with the start pulse, only when idle
    always_ff @(posedge clk) begin
        if (start && (phase == `DFE_PH_IDLE)) begin
            offset_q <= oc_offset;
        end
    end

    // odd field in the low nibble, even field in the next one
    assign ofs_od = offset_q[`DFE_OFFSET_FIELD_W-1:0];
    assign ofs_ev = offset_q[2*`DFE_OFFSET_FIELD_W-1:`DFE_OFFSET_FIELD_W];

    // -------------------------------------------------------------------
    // opcode, address and write word per phase and count
    // -------------------------------------------------------------------
    always_comb begin
        opcode = `DFE_OP_WR;
        addr   = '0;
        word   = '0;
        case (phase)
            `DFE_PH_SAVE: begin
                opcode = `DFE_OP_RD;
                case (count)
                    2'd0:    addr = `DFE_ADDR_8;
                    2'd1:    addr = `DFE_ADDR_11;
                    2'd2:    addr = `DFE_ADDR_12;
                    default: addr = `DFE_ADDR_13;
                endcase
            end
            `DFE_PH_OC_SETUP: begin
                if (count == 2'd0) begin
                    // stop adaptation while the offset is applied
                    addr              = `DFE_ADDR_11;
                    word              = saved_11;
                    word.r11.adapt_en = 1'b0;
                end else begin
                    addr             = `DFE_ADDR_12;
                    word             = saved_12;
                    word.r12.pdof_ev = '0;
                    word.r12.pdof_od = '0;
                    word.r12.pdb     = 1'b1;
                end
            end
            `DFE_PH_OC_APPLY: begin
                if (count == 2'd0) begin
                    addr             = `DFE_ADDR_12;
                    word             = saved_12;
                    word.r12.pdof_ev = ofs_ev;
                    word.r12.pdof_od = ofs_od;
                    word.r12.pdb     = 1'b1;
                end else begin
                    // upper offset bits go straight to register 15
                    addr = `DFE_ADDR_15;
                    word = offset_q[`DFE_OFFSET_W-1:2*`DFE_OFFSET_FIELD_W];
                end
            end
            `DFE_PH_RESTORE: begin
                case (count)
                    2'd0: begin
                        addr = `DFE_ADDR_8;
                        word = saved_8;
                    end
                    2'd1: begin
                        addr = `DFE_ADDR_11;
                        word = saved_11;
                    end
                    2'd2: begin
                        // user pdb comes back, the new offset stays
                        addr             = `DFE_ADDR_12;
                        word             = saved_12;
                        word.r12.pdof_ev = ofs_ev;
                        word.r12.pdof_od = ofs_od;
                    end
                    default: begin
                        addr = `DFE_ADDR_13;
                        word = saved_13;
                    end
                endcase
            end
            default: begin
                opcode = `DFE_OP_WR;
            end
        endcase
    end

    assign wdata = word;

endmodule

//--- hdl/dfe_save_bank.sv
`include "dfe_cal_params.svh"

module dfe_save_bank (
    input  logic                  clk,
    input  logic [`DFE_PH_W-1:0]  phase,
    input  logic [`DFE_CNT_W-1:0] count,
    input  logic [`DFE_WORD_W-1:0] ctrl_rdata,
    input  logic                  ctrl_done,
    output dfe_cal_pkg::dfe_reg_u saved_8,
    output dfe_cal_pkg::dfe_reg_u saved_11,
    output dfe_cal_pkg::dfe_reg_u saved_12,
    output dfe_cal_pkg::dfe_reg_u saved_13
);

    // -------------------------------------------------------------------
    // user settings read back during the save burst
    // -------------------------------------------------------------------
    // count follows the read order 8, 11, 12, 13
    always_ff @(posedge clk) begin
        if ((phase == `DFE_PH_SAVE) && ctrl_done) begin
            case (count)
                2'd0:    saved_8  <= ctrl_rdata;
                2'd1:    saved_11 <= ctrl_rdata;
                2'd2:    saved_12 <= ctrl_rdata;
                default: saved_13 <= ctrl_rdata;
            endcase
        end
    end

    // all four reads have landed before the first overlay write
    // and the words stay put until restore has used them
    assert property (@(posedge clk)
        ((phase != `DFE_PH_IDLE) && (phase != `DFE_PH_SAVE)) |->
            (!$isunknown({saved_8, saved_11, saved_12, saved_13}) &&
             $stable({saved_8, saved_11, saved_12, saved_13})))
        else $error("saved register word unknown or changed outside the save phase");

endmodule

//--- hdl/dfe_cal_sequencer.sv
`include "dfe_cal_params.svh"

module dfe_cal_sequencer (
    input  logic                  clk,
    input  logic                  reg_count_reset,
    input  logic                  start,
    input  logic                  step_done,
    output logic [`DFE_PH_W-1:0]  phase,
    output logic [`DFE_CNT_W-1:0] count,
    output logic                  issue,
    output logic                  ctrl_lock,
    output logic                  busy,
    output logic                  done
);

    logic [`DFE_PH_W-1:0]  phase_q;
    logic [`DFE_CNT_W-1:0] count_q;
    logic                  run_q;
    logic [`DFE_CNT_W-1:0] last_count;
    logic [`DFE_PH_W-1:0]  next_phase;
    logic                  accept;
    logic                  burst_end;
    logic                  run_end;

    // start is only taken while no run is in flight
    assign accept    = start && !run_q;
    assign burst_end = (count_q == last_count);
    assign run_end   = step_done && burst_end && (phase_q == `DFE_PH_RESTORE);

    // -------------------------------------------------------------------
    // burst length and successor of each phase
    // -------------------------------------------------------------------
    always_comb begin
        case (phase_q)
            `DFE_PH_SAVE: begin
                last_count = `DFE_LAST_SAVE;
                next_phase = `DFE_PH_OC_SETUP;
            end
            `DFE_PH_OC_SETUP: begin
                last_count = `DFE_LAST_OC_SETUP;
                next_phase = `DFE_PH_OC_APPLY;
            end
            `DFE_PH_OC_APPLY: begin
                last_count = `DFE_LAST_OC_APPLY;
                next_phase = `DFE_PH_RESTORE;
            end
            `DFE_PH_RESTORE: begin
                last_count = `DFE_LAST_RESTORE;
                next_phase = `DFE_PH_IDLE;
            end
            default: begin
                last_count = '0;
                next_phase = `DFE_PH_IDLE;
            end
        endcase
    end

    // -------------------------------------------------------------------
    // phase register, burst counter, lock and done
    // -------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reg_count_reset) begin
            phase_q <= `DFE_PH_IDLE;
            count_q <= '0;
            run_q   <= 1'b0;
            issue   <= 1'b0;
            done    <= 1'b0;
        end else begin
            issue <= 1'b0;
            done  <= 1'b0;
            if (accept) begin
                phase_q <= `DFE_PH_SAVE;
                count_q <= '0;
                run_q   <= 1'b1;
                issue   <= 1'b1;
            end else if (step_done && run_q) begin
                if (burst_end) begin
                    phase_q <= next_phase;
                    count_q <= '0;
                end else begin
                    count_q <= count_q + 1'b1;
                end
                // the last restore write closes the run and any other completion fires
                // the next request
                if (run_end) begin
                    run_q <= 1'b0;
                    done  <= 1'b1;
                end else begin
                    issue <= 1'b1;
                end
            end
        end
    end

    assign phase     = phase_q;
    assign count     = count_q;
    assign busy      = run_q;
    assign ctrl_lock = run_q;

    // phase stays within the five defined codes and is IDLE exactly while no run is open
    assert property (@(posedge clk) disable iff (reg_count_reset)
        (phase_q <= `DFE_PH_RESTORE) && ((phase_q == `DFE_PH_IDLE) == !run_q))
        else $error("sequencer phase %0d out of step with the run flag", phase_q);

endmodule

//--- hdl/dfe_cal_pkg.sv
`include "dfe_cal_params.svh"

package dfe_cal_pkg;

    // -------------------------------------------------------------------
    // one register data word, decoded by the register it belongs to
    // -------------------------------------------------------------------
    typedef union packed {
        // register 11: adaptation enable on top of the tap settings
        struct packed {
            logic                                 adapt_en;
            logic [`DFE_ADAPT_EN_BIT-1:0]         taps;
        } r11;
        // register 12: power-down bar and the even/odd offset fields
        struct packed {
            logic [`DFE_WORD_W-`DFE_PDB_BIT-2:0]  upper;
            logic                                 pdb;
            logic [`DFE_OFFSET_FIELD_W-1:0]       pdof_ev;
            logic [`DFE_OFFSET_FIELD_W-1:0]       pdof_od;
        } r12;
    } dfe_reg_u;

endpackage

//--- hdl/dfe_cal_params.svh
`ifndef DFE_CAL_PARAMS_SVH
`define DFE_CAL_PARAMS_SVH

// bus and data widths
`define DFE_ADDR_W          12
`define DFE_WORD_W          16
`define DFE_OFFSET_W        24
`define DFE_OFFSET_FIELD_W  4

// user register addresses for channel 0
`define DFE_ADDR_8          12'h108
`define DFE_ADDR_11         12'h10B
`define DFE_ADDR_12         12'h10C
`define DFE_ADDR_13         12'h10D
`define DFE_ADDR_15         12'h10F

// bus opcodes
`define DFE_OP_RD           3'b001
`define DFE_OP_WR           3'b010

// sequencer phases
`define DFE_PH_W            3
`define DFE_PH_IDLE         3'd0
`define DFE_PH_SAVE         3'd1
`define DFE_PH_OC_SETUP     3'd2
`define DFE_PH_OC_APPLY     3'd3
`define DFE_PH_RESTORE      3'd4

// burst counter and the last count of each burst
`define DFE_CNT_W           2
`define DFE_LAST_SAVE       2'd3
`define DFE_LAST_OC_SETUP   2'd1
`define DFE_LAST_OC_APPLY   2'd1
`define DFE_LAST_RESTORE    2'd3

// control bits inside registers 11 and 12
`define DFE_ADAPT_EN_BIT    15
`define DFE_PDB_BIT         8

`endif
